//--- common/dcache_geom_pkg.sv
// data cache geometry

package dcache_geom_pkg;

  // set associativity
  parameter int unsigned NumWays   = 4;

  // tag and set index widths
  parameter int unsigned TagWidth  = 8;
  parameter int unsigned IdxWidth  = 4;
  parameter int unsigned NumSets   = 2 ** IdxWidth;

  // byte offset inside one cacheline
  parameter int unsigned OffWidth  = 5;

  // one line is four 64-bit words
  parameter int unsigned LineWidth = 256;

endpackage

//--- common/dcache_bank_pkg.sv
// data bank mapping

package dcache_bank_pkg;

  // one word per bank access
  parameter int unsigned WordWidth    = 64;
  parameter int unsigned WordBytes    = WordWidth / 8;

  // each word offset of a line lives in its own bank
  parameter int unsigned NumBanks     = 4;
  parameter int unsigned BankSelWidth = $clog2(NumBanks);

  // word offset to one-hot bank vector
  function automatic logic [NumBanks-1:0] bank_onehot(input logic [BankSelWidth-1:0] sel);
    logic [NumBanks-1:0] oh;
    oh      = '0;
    oh[sel] = 1'b1;
    return oh;
  endfunction

endpackage

//--- hdl/dcache_rr_arb.sv
// round robin arbiter

module dcache_rr_arb #(
  parameter int unsigned NumPorts = 3
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic [NumPorts-1:0]         req_i,
  output logic [NumPorts-1:0]         gnt_o,
  output logic [$clog2(NumPorts)-1:0] idx_o,
  output logic                        req_o
);

  localparam int unsigned IdxW = $clog2(NumPorts);

  // last granted port
  logic [IdxW-1:0] ptr_q;

  assign req_o = |req_i;

  // search starts right after the last winner and wraps around
  always_comb begin
    int unsigned cand;
    logic        found;
    found = 1'b0;
    idx_o = '0;
    gnt_o = '0;
    for (int unsigned i = 0; i < NumPorts; i++) begin
      cand = (32'(ptr_q) + 1 + i) % NumPorts;
      if (!found && req_i[cand]) begin
        found = 1'b1;
        idx_o = IdxW'(cand);
      end
    end
    gnt_o[idx_o] = found;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= IdxW'(NumPorts - 1);
    end else if (req_o) begin
      ptr_q <= idx_o;
    end
  end

  // a port wins twice in a row only when nobody else asks
  gnt_fair: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0(gnt_o) &&
      !(req_o && $past(req_o) && $past(rst_ni) && gnt_o == $past(gnt_o) && !$onehot(req_i)))
    else $error("round robin grant not fair or not one-hot");

endmodule

//--- hdl/dcache_mem_ctrl.sv
// data cache access control

module dcache_mem_ctrl #(
  parameter int unsigned NumPorts = 3
) (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  logic [NumPorts-1:0]                                    rd_req_i,
  input  logic [NumPorts-1:0][dcache_geom_pkg::IdxWidth-1:0]     rd_idx_i,
  input  logic [NumPorts-1:0][dcache_geom_pkg::OffWidth-1:0]     rd_off_i,
  input  logic [NumPorts-1:0][dcache_geom_pkg::TagWidth-1:0]     rd_tag_i,
  input  logic [NumPorts-1:0]                                    rd_tag_only_i,
  input  logic [NumPorts-1:0]                                    rd_prio_i,
  input  logic                                                   wr_cl_vld_i,
  input  logic [dcache_geom_pkg::NumWays-1:0]                    wr_cl_we_i,
  input  logic [dcache_geom_pkg::IdxWidth-1:0]                   wr_cl_idx_i,
  input  logic [dcache_geom_pkg::OffWidth-1:0]                   wr_cl_off_i,
  input  logic [dcache_geom_pkg::NumWays-1:0]                    wr_req_i,
  input  logic [dcache_geom_pkg::IdxWidth-1:0]                   wr_idx_i,
  input  logic [dcache_geom_pkg::OffWidth-1:0]                   wr_off_i,
  output logic [NumPorts-1:0]                                    rd_ack_o,
  output logic                                                   wr_ack_o,
  output logic [dcache_geom_pkg::NumWays-1:0]                    tag_req_o,
  output logic                                                   tag_we_o,
  output logic [dcache_geom_pkg::IdxWidth-1:0]                   tag_idx_o,
  output logic [dcache_bank_pkg::NumBanks-1:0]                   bank_req_o,
  output logic [dcache_bank_pkg::NumBanks-1:0]                   bank_we_o,
  output logic [dcache_bank_pkg::NumBanks-1:0][dcache_geom_pkg::IdxWidth-1:0] bank_idx_o,
  output logic [dcache_geom_pkg::TagWidth-1:0]                   rd_tag_o,
  output logic [dcache_bank_pkg::BankSelWidth-1:0]               bank_sel_q_o,
  output logic                                                   cmp_en_q_o
);

  import dcache_geom_pkg::*;
  import dcache_bank_pkg::*;

  localparam int unsigned PortIdxW = $clog2(NumPorts);

  logic [NumPorts-1:0]     rd_req_prio;
  logic [NumPorts-1:0]     rd_req_masked;
  logic [PortIdxW-1:0]     sel_d;
  logic [PortIdxW-1:0]     sel_q;
  logic                    rd_acked;
  logic                    rd_data_acc;
  logic [BankSelWidth-1:0] rd_bank;
  logic [BankSelWidth-1:0] wr_bank;
  logic [BankSelWidth-1:0] bank_sel_d;

  ////////////////////////////////////////////////////////////////////////////
  // priority masking and arbitration
  ////////////////////////////////////////////////////////////////////////////

  // high prio requests shut out all low prio ones
  assign rd_req_prio   = rd_req_i & rd_prio_i;
  // a refill owns the arrays, so nobody competes and the pointer holds
  assign rd_req_masked = ((|rd_req_prio) ? rd_req_prio : rd_req_i) & {NumPorts{~wr_cl_vld_i}};

  dcache_rr_arb #(
    .NumPorts (NumPorts)
  ) u_rr_arb (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (rd_req_masked),
    .gnt_o  (rd_ack_o),
    .idx_o  (sel_d),
    .req_o  (rd_acked)
  );

  assign rd_data_acc = rd_acked & ~rd_tag_only_i[sel_d];
  assign rd_bank     = rd_off_i[sel_d][OffWidth-1 -: BankSelWidth];
  assign wr_bank     = wr_off_i[OffWidth-1 -: BankSelWidth];
  assign bank_sel_d  = wr_cl_vld_i ? wr_cl_off_i[OffWidth-1 -: BankSelWidth] : rd_bank;

  // tag array, refill writes the selected ways, a read looks up all ways
  assign tag_we_o  = wr_cl_vld_i;
  assign tag_req_o = wr_cl_vld_i ? wr_cl_we_i : {NumWays{rd_acked}};
  assign tag_idx_o = wr_cl_vld_i ? wr_cl_idx_i : rd_idx_i[sel_d];

  ////////////////////////////////////////////////////////////////////////////
  // bank requests
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    bank_req_o = '0;
    bank_we_o  = '0;
    bank_idx_o = {NumBanks{wr_idx_i}};
    wr_ack_o   = 1'b0;
    if (wr_cl_vld_i) begin
      if (|wr_cl_we_i) begin
        bank_req_o = '1;
        bank_we_o  = '1;
        bank_idx_o = {NumBanks{wr_cl_idx_i}};
      end
    end else begin
      if (rd_data_acc) begin
        bank_req_o          = bank_onehot(rd_bank);
        bank_idx_o[rd_bank] = rd_idx_i[sel_d];
      end
      // word write only loses against a data read of the same bank
      if ((|wr_req_i) && !(rd_data_acc && (rd_bank == wr_bank))) begin
        wr_ack_o   = 1'b1;
        bank_req_o = bank_req_o | bank_onehot(wr_bank);
        bank_we_o  = bank_onehot(wr_bank);
      end
    end
  end

  // read pipeline stage
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q        <= '0;
      bank_sel_q_o <= '0;
      cmp_en_q_o   <= 1'b0;
    end else begin
      sel_q        <= sel_d;
      bank_sel_q_o <= bank_sel_d;
      cmp_en_q_o   <= rd_acked;
    end
  end

  // the tag of the granted port comes one cycle late
  assign rd_tag_o = rd_tag_i[sel_q];

  word_write_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni) wr_ack_o |-> $onehot(wr_req_i))
    else $error("word write acknowledged with a non one-hot way vector");

endmodule

//--- hdl/dcache_tag_array.sv
// tag array and hit compare

module dcache_tag_array (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic [dcache_geom_pkg::NumWays-1:0]  tag_req_i,
  input  logic                                 tag_we_i,
  input  logic [dcache_geom_pkg::IdxWidth-1:0] tag_idx_i,
  input  logic [dcache_geom_pkg::TagWidth-1:0] wr_tag_i,
  input  logic [dcache_geom_pkg::NumWays-1:0]  wr_vld_i,
  input  logic [dcache_geom_pkg::TagWidth-1:0] rd_tag_i,
  input  logic                                 cmp_en_i,
  output logic [dcache_geom_pkg::NumWays-1:0]  vld_bits_o,
  output logic [dcache_geom_pkg::NumWays-1:0]  hit_oh_o
);

  import dcache_geom_pkg::*;

  logic [TagWidth-1:0]              tag_mem [NumWays][NumSets];
  logic [NumSets-1:0]               vld_q   [NumWays];
  logic [NumWays-1:0][TagWidth-1:0] tag_rdata_q;

  for (genvar w = 0; w < NumWays; w++) begin : gen_way
    // tag storage with one cycle read
    always_ff @(posedge clk_i) begin
      if (tag_req_i[w]) begin
        if (tag_we_i) begin
          tag_mem[w][tag_idx_i] <= wr_tag_i;
        end else begin
          tag_rdata_q[w] <= tag_mem[w][tag_idx_i];
        end
      end
    end

    // valid bits
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        vld_q[w]      <= '0;
        vld_bits_o[w] <= 1'b0;
      end else if (tag_req_i[w]) begin
        if (tag_we_i) begin
          vld_q[w][tag_idx_i] <= wr_vld_i[w];
        end else begin
          vld_bits_o[w] <= vld_q[w][tag_idx_i];
        end
      end
    end

    assign hit_oh_o[w] = cmp_en_i & vld_bits_o[w] & (tag_rdata_q[w] == rd_tag_i);
  end

  // refills never allocate the same tag twice in a set
  hit_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (|tag_req_i) && !tag_we_i |=> $onehot0(hit_oh_o))
    else $error("tag lookup hit in more than one way");

endmodule

//--- hdl/dcache_data_banks.sv
// word interleaved data banks

module dcache_data_banks (
  input  logic                                   clk_i,
  input  logic [dcache_bank_pkg::NumBanks-1:0]   bank_req_i,
  input  logic [dcache_bank_pkg::NumBanks-1:0]   bank_we_i,
  input  logic [dcache_bank_pkg::NumBanks-1:0][dcache_geom_pkg::IdxWidth-1:0] bank_idx_i,
  input  logic                                   wr_cl_vld_i,
  input  logic [dcache_geom_pkg::NumWays-1:0]    wr_cl_we_i,
  input  logic [dcache_geom_pkg::LineWidth-1:0]  wr_cl_data_i,
  input  logic [dcache_geom_pkg::LineWidth/8-1:0] wr_cl_data_be_i,
  input  logic [dcache_geom_pkg::NumWays-1:0]    wr_req_i,
  input  logic                                   wr_ack_i,
  input  logic [dcache_bank_pkg::WordWidth-1:0]  wr_data_i,
  input  logic [dcache_bank_pkg::WordBytes-1:0]  wr_data_be_i,
  output logic [dcache_bank_pkg::NumBanks-1:0][dcache_geom_pkg::NumWays-1:0]
               [dcache_bank_pkg::WordWidth-1:0]  bank_rdata_o
);

  import dcache_geom_pkg::*;
  import dcache_bank_pkg::*;

  // one entry of a bank holds this word for all ways
  logic [NumWays-1:0][WordWidth-1:0] mem [NumBanks][NumSets];
  logic [NumBanks-1:0][NumWays-1:0][WordBytes-1:0] bank_be;
  logic [NumBanks-1:0][NumWays-1:0][WordWidth-1:0] bank_wdata;

  for (genvar k = 0; k < NumBanks; k++) begin : gen_bank
    for (genvar j = 0; j < NumWays; j++) begin : gen_way
      // refill wins over the word write
      assign bank_be[k][j] = (wr_cl_vld_i & wr_cl_we_i[j]) ?
                             wr_cl_data_be_i[k*WordBytes +: WordBytes] :
                             (wr_ack_i & wr_req_i[j]) ? wr_data_be_i : '0;
      assign bank_wdata[k][j] = (wr_cl_vld_i & wr_cl_we_i[j]) ?
                                wr_cl_data_i[k*WordWidth +: WordWidth] : wr_data_i;
    end

    always_ff @(posedge clk_i) begin
      if (bank_req_i[k]) begin
        if (bank_we_i[k]) begin
          for (int j = 0; j < NumWays; j++) begin
            for (int b = 0; b < WordBytes; b++) begin
              if (bank_be[k][j][b]) begin
                mem[k][bank_idx_i[k]][j][8*b +: 8] <= bank_wdata[k][j][8*b +: 8];
              end
            end
          end
        end else begin
          bank_rdata_o[k] <= mem[k][bank_idx_i[k]];
        end
      end
    end
  end

endmodule

//--- hdl/dcache_read_mux.sv
// read word select

module dcache_read_mux (
  input  logic [dcache_bank_pkg::NumBanks-1:0][dcache_geom_pkg::NumWays-1:0]
               [dcache_bank_pkg::WordWidth-1:0]     bank_rdata_i,
  input  logic [dcache_bank_pkg::BankSelWidth-1:0]  bank_sel_q_i,
  input  logic [dcache_geom_pkg::NumWays-1:0]       hit_oh_i,
  input  logic                                      wr_cl_vld_i,
  input  logic [dcache_geom_pkg::OffWidth-1:0]      wr_cl_off_i,
  input  logic [dcache_geom_pkg::LineWidth-1:0]     wr_cl_data_i,
  output logic [dcache_bank_pkg::WordWidth-1:0]     rd_data_o
);

  import dcache_geom_pkg::*;
  import dcache_bank_pkg::*;

  localparam int unsigned WayIdxW = $clog2(NumWays);

  logic [WayIdxW-1:0]      hit_idx;
  logic [BankSelWidth-1:0] cl_word;

  // one-hot hit to way index
  always_comb begin
    hit_idx = '0;
    for (int unsigned j = 0; j < NumWays; j++) begin
      if (hit_oh_i[j]) begin
        hit_idx = hit_idx | WayIdxW'(j);
      end
    end
  end

  assign cl_word = wr_cl_off_i[OffWidth-1 -: BankSelWidth];

  // refill word bypasses the arrays
  assign rd_data_o = wr_cl_vld_i ? wr_cl_data_i[cl_word*WordWidth +: WordWidth] :
                                   bank_rdata_i[bank_sel_q_i][hit_idx];

endmodule

//--- hdl/dcache_mem.sv
// data cache memory block

module dcache_mem #(
  parameter int unsigned NumPorts = 3
) (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  // read ports, tag arrives one cycle after the grant
  input  logic [NumPorts-1:0]                                   rd_req_i,
  input  logic [NumPorts-1:0][dcache_geom_pkg::IdxWidth-1:0]    rd_idx_i,
  input  logic [NumPorts-1:0][dcache_geom_pkg::OffWidth-1:0]    rd_off_i,
  input  logic [NumPorts-1:0][dcache_geom_pkg::TagWidth-1:0]    rd_tag_i,
  input  logic [NumPorts-1:0]                                   rd_tag_only_i,
  input  logic [NumPorts-1:0]                                   rd_prio_i,
  output logic [NumPorts-1:0]                                   rd_ack_o,
  output logic [dcache_geom_pkg::NumWays-1:0]                   rd_vld_bits_o,
  output logic [dcache_geom_pkg::NumWays-1:0]                   rd_hit_oh_o,
  output logic [dcache_bank_pkg::WordWidth-1:0]                 rd_data_o,
  // cacheline refill
  input  logic                                                  wr_cl_vld_i,
  input  logic [dcache_geom_pkg::NumWays-1:0]                   wr_cl_we_i,
  input  logic [dcache_geom_pkg::TagWidth-1:0]                  wr_cl_tag_i,
  input  logic [dcache_geom_pkg::IdxWidth-1:0]                  wr_cl_idx_i,
  input  logic [dcache_geom_pkg::OffWidth-1:0]                  wr_cl_off_i,
  input  logic [dcache_geom_pkg::LineWidth-1:0]                 wr_cl_data_i,
  input  logic [dcache_geom_pkg::LineWidth/8-1:0]               wr_cl_data_be_i,
  input  logic [dcache_geom_pkg::NumWays-1:0]                   wr_vld_bits_i,
  // single word write
  input  logic [dcache_geom_pkg::NumWays-1:0]                   wr_req_i,
  input  logic [dcache_geom_pkg::IdxWidth-1:0]                  wr_idx_i,
  input  logic [dcache_geom_pkg::OffWidth-1:0]                  wr_off_i,
  input  logic [dcache_bank_pkg::WordWidth-1:0]                 wr_data_i,
  input  logic [dcache_bank_pkg::WordBytes-1:0]                 wr_data_be_i,
  output logic                                                  wr_ack_o
);

  import dcache_geom_pkg::*;
  import dcache_bank_pkg::*;

  logic [NumWays-1:0]                         tag_req;
  logic                                       tag_we;
  logic [IdxWidth-1:0]                        tag_idx;
  logic [TagWidth-1:0]                        rd_tag;
  logic                                       cmp_en_q;
  logic [NumBanks-1:0]                        bank_req;
  logic [NumBanks-1:0]                        bank_we;
  logic [NumBanks-1:0][IdxWidth-1:0]          bank_idx;
  logic [BankSelWidth-1:0]                    bank_sel_q;
  logic [NumBanks-1:0][NumWays-1:0][WordWidth-1:0] bank_rdata;

  dcache_mem_ctrl #(
    .NumPorts (NumPorts)
  ) u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_req_i      (rd_req_i),
    .rd_idx_i      (rd_idx_i),
    .rd_off_i      (rd_off_i),
    .rd_tag_i      (rd_tag_i),
    .rd_tag_only_i (rd_tag_only_i),
    .rd_prio_i     (rd_prio_i),
    .wr_cl_vld_i   (wr_cl_vld_i),
    .wr_cl_we_i    (wr_cl_we_i),
    .wr_cl_idx_i   (wr_cl_idx_i),
    .wr_cl_off_i   (wr_cl_off_i),
    .wr_req_i      (wr_req_i),
    .wr_idx_i      (wr_idx_i),
    .wr_off_i      (wr_off_i),
    .rd_ack_o      (rd_ack_o),
    .wr_ack_o      (wr_ack_o),
    .tag_req_o     (tag_req),
    .tag_we_o      (tag_we),
    .tag_idx_o     (tag_idx),
    .bank_req_o    (bank_req),
    .bank_we_o     (bank_we),
    .bank_idx_o    (bank_idx),
    .rd_tag_o      (rd_tag),
    .bank_sel_q_o  (bank_sel_q),
    .cmp_en_q_o    (cmp_en_q)
  );

  dcache_tag_array u_tag_array (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .tag_req_i  (tag_req),
    .tag_we_i   (tag_we),
    .tag_idx_i  (tag_idx),
    .wr_tag_i   (wr_cl_tag_i),
    .wr_vld_i   (wr_vld_bits_i),
    .rd_tag_i   (rd_tag),
    .cmp_en_i   (cmp_en_q),
    .vld_bits_o (rd_vld_bits_o),
    .hit_oh_o   (rd_hit_oh_o)
  );

  dcache_data_banks u_data_banks (
    .clk_i           (clk_i),
    .bank_req_i      (bank_req),
    .bank_we_i       (bank_we),
    .bank_idx_i      (bank_idx),
    .wr_cl_vld_i     (wr_cl_vld_i),
    .wr_cl_we_i      (wr_cl_we_i),
    .wr_cl_data_i    (wr_cl_data_i),
    .wr_cl_data_be_i (wr_cl_data_be_i),
    .wr_req_i        (wr_req_i),
    .wr_ack_i        (wr_ack_o),
    .wr_data_i       (wr_data_i),
    .wr_data_be_i    (wr_data_be_i),
    .bank_rdata_o    (bank_rdata)
  );

  dcache_read_mux u_read_mux (
    .bank_rdata_i  (bank_rdata),
    .bank_sel_q_i  (bank_sel_q),
    .hit_oh_i      (rd_hit_oh_o),
    .wr_cl_vld_i   (wr_cl_vld_i),
    .wr_cl_off_i   (wr_cl_off_i),
    .wr_cl_data_i  (wr_cl_data_i),
    .rd_data_o     (rd_data_o)
  );

endmodule

//--- testbench/tb_dcache_tasks.svh
// data cache directed tests

`ifndef TB_DCACHE_TASKS_SVH
`define TB_DCACHE_TASKS_SVH

  // expected contents of every line written so far
  logic [WordWidth-1:0] ref_data [NumWays][NumSets][NumBanks];
  logic [TagWidth-1:0]  ref_tag  [NumWays][NumSets];
  logic [NumWays-1:0]   ref_vld  [NumSets];

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch at time %0t: %s expected %h, actual %h", $time, name, exp, act);
    end
  endtask

  task automatic clear_inputs();
    rd_req_i      = '0;
    rd_idx_i      = '0;
    rd_off_i      = '0;
    rd_tag_i      = '0;
    rd_tag_only_i = '0;
    rd_prio_i     = '0;
    wr_cl_vld_i   = 1'b0;
    wr_cl_we_i    = '0;
    wr_cl_tag_i   = '0;
    wr_cl_idx_i   = '0;
    wr_cl_off_i   = '0;
    wr_cl_data_i  = '0;
    wr_cl_data_be_i = '0;
    wr_vld_bits_i = '0;
    wr_req_i      = '0;
    wr_idx_i      = '0;
    wr_off_i      = '0;
    wr_data_i     = '0;
    wr_data_be_i  = '0;
  endtask

  function automatic logic [LineWidth-1:0] random_line();
    logic [LineWidth-1:0] l;
    for (int i = 0; i < LineWidth / 32; i++) begin
      l[i*32 +: 32] = $urandom;
    end
    return l;
  endfunction

  // a way hits when it is valid and holds the looked up tag
  function automatic logic [NumWays-1:0] exp_hit(input logic [IdxWidth-1:0] idx,
                                                input logic [TagWidth-1:0] tag);
    logic [NumWays-1:0] h;
    for (int w = 0; w < NumWays; w++) begin
      h[w] = ref_vld[idx][w] && (ref_tag[w][idx] == tag);
    end
    return h;
  endfunction

  task automatic merge_word(input int way, input logic [IdxWidth-1:0] idx, input int word,
                            input logic [WordWidth-1:0] data, input logic [WordBytes-1:0] be);
    for (int b = 0; b < WordBytes; b++) begin
      if (be[b]) begin
        ref_data[way][idx][word][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  task automatic set_read(input int p, input logic [IdxWidth-1:0] idx, input int word,
                          input logic tag_only);
    rd_req_i[p]      = 1'b1;
    rd_idx_i[p]      = idx;
    rd_off_i[p]      = OffWidth'(word * WordBytes);
    rd_tag_only_i[p] = tag_only;
  endtask

  task automatic set_write(input int way, input logic [IdxWidth-1:0] idx, input int word,
                           input logic [WordWidth-1:0] data, input logic [WordBytes-1:0] be);
    wr_req_i     = NumWays'(1 << way);
    wr_idx_i     = idx;
    wr_off_i     = OffWidth'(word * WordBytes);
    wr_data_i    = data;
    wr_data_be_i = be;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // port level operations
  ////////////////////////////////////////////////////////////////////////////

  // request until granted, then present the tag in the following cycle
  task automatic read_word(input int p, input logic [IdxWidth-1:0] idx, input int word,
                           input logic [TagWidth-1:0] tag);
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    set_read(p, idx, word, 1'b0);
    #(ClkPeriod/4);
    while (!rd_ack_o[p] && n < 8) begin
      @(negedge clk_i);
      #(ClkPeriod/4);
      n++;
    end
    if (!rd_ack_o[p]) begin
      errors++;
      $display("read on port %0d was never granted", p);
    end
    @(negedge clk_i);
    rd_req_i[p] = 1'b0;
    rd_tag_i[p] = tag;
    #(ClkPeriod/4);
  endtask

  task automatic read_check(input int p, input logic [IdxWidth-1:0] idx, input int word,
                            input logic [TagWidth-1:0] tag);
    logic [NumWays-1:0] hit;
    read_word(p, idx, word, tag);
    hit = exp_hit(idx, tag);
    check_val("rd_vld_bits_o", 64'(ref_vld[idx]), 64'(rd_vld_bits_o));
    check_val("rd_hit_oh_o", 64'(hit), 64'(rd_hit_oh_o));
    for (int w = 0; w < NumWays; w++) begin
      if (hit[w]) begin
        check_val("rd_data_o", ref_data[w][idx][word], rd_data_o);
      end
    end
  endtask

  // one refill cycle per step, with the offset moving and reads held pending
  task automatic refill_line(input int way, input logic [IdxWidth-1:0] idx,
                             input logic [TagWidth-1:0] tag, input logic [LineWidth-1:0] line,
                             input int n_cycles, input logic [NumPorts-1:0] pend);
    int word;
    for (int c = 0; c < n_cycles; c++) begin
      word = (c + 1) % NumBanks;
      @(negedge clk_i);
      rd_req_i        = pend;
      wr_cl_vld_i     = 1'b1;
      wr_cl_we_i      = NumWays'(1 << way);
      wr_cl_tag_i     = tag;
      wr_cl_idx_i     = idx;
      wr_cl_off_i     = OffWidth'(word * WordBytes);
      wr_cl_data_i    = line;
      wr_cl_data_be_i = '1;
      wr_vld_bits_i   = NumWays'(1 << way);
      #(ClkPeriod/4);
      check_val("rd_ack_o", '0, 64'(rd_ack_o));
      check_val("rd_data_o", line[word*WordWidth +: WordWidth], rd_data_o);
    end
    @(negedge clk_i);
    rd_req_i    = '0;
    wr_cl_vld_i = 1'b0;
    wr_cl_we_i  = '0;
    ref_tag[way][idx] = tag;
    ref_vld[idx][way] = 1'b1;
    for (int k = 0; k < NumBanks; k++) begin
      ref_data[way][idx][k] = line[k*WordWidth +: WordWidth];
    end
  endtask

  task automatic write_word(input int way, input logic [IdxWidth-1:0] idx, input int word,
                            input logic [WordWidth-1:0] data, input logic [WordBytes-1:0] be);
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    set_write(way, idx, word, data, be);
    #(ClkPeriod/4);
    while (!wr_ack_o && n < 8) begin
      @(negedge clk_i);
      #(ClkPeriod/4);
      n++;
    end
    if (!wr_ack_o) begin
      errors++;
      $display("word write to set %0d was never acknowledged", idx);
    end else begin
      merge_word(way, idx, word, data, be);
    end
    @(negedge clk_i);
    wr_req_i = '0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    for (int s = 0; s < NumSets; s++) begin
      ref_vld[s] = '0;
    end
    #(ClkPeriod/4);
    check_val("rd_ack_o", '0, 64'(rd_ack_o));
    check_val("wr_ack_o", '0, 64'(wr_ack_o));
    check_val("rd_hit_oh_o", '0, 64'(rd_hit_oh_o));
    check_val("rd_vld_bits_o", '0, 64'(rd_vld_bits_o));
    for (int p = 0; p < NumPorts; p++) begin
      read_check(p, IdxWidth'(p * 5), p % NumBanks, TagWidth'($urandom));
    end
  endtask

  task automatic test_refill_read();
    logic [TagWidth-1:0] tag;
    tag = TagWidth'($urandom);
    refill_line(2, IdxWidth'(5), tag, random_line(), 1, NumPorts'(1));
    for (int w = 0; w < NumBanks; w++) begin
      read_check(w % NumPorts, IdxWidth'(5), w, tag);
    end
    // another tag in the same set misses
    read_check(0, IdxWidth'(5), 0, tag ^ TagWidth'(8'h5a));
  endtask

  task automatic test_refill_bypass();
    logic [TagWidth-1:0] tag;
    tag = TagWidth'($urandom);
    refill_line(0, IdxWidth'(9), tag, random_line(), 3, '1);
    read_check(1, IdxWidth'(9), 2, tag);
  endtask

  task automatic test_priority_rr();
    logic [NumPorts-1:0] prev;
    @(negedge clk_i);
    rd_req_i  = NumPorts'(3);
    rd_prio_i = NumPorts'(2);
    repeat (2) begin
      #(ClkPeriod/4);
      check_val("rd_ack_o", 64'(NumPorts'(2)), 64'(rd_ack_o));
      @(negedge clk_i);
    end
    // all ports on equal priority, grants walk upwards
    rd_prio_i = '0;
    rd_req_i  = '1;
    #(ClkPeriod/4);
    prev = rd_ack_o;
    checks++;
    if (!$onehot(prev)) begin
      errors++;
      $display("first round robin grant is not one-hot: %b", prev);
    end
    repeat (2 * NumPorts) begin
      @(negedge clk_i);
      #(ClkPeriod/4);
      check_val("rd_ack_o", 64'({prev[NumPorts-2:0], prev[NumPorts-1]}), 64'(rd_ack_o));
      prev = rd_ack_o;
    end
    @(negedge clk_i);
    rd_req_i = '0;
  endtask

  task automatic test_word_write();
    write_word(2, IdxWidth'(5), 1, {$urandom, $urandom}, 8'h3c);
    read_check(0, IdxWidth'(5), 1, ref_tag[2][5]);
  endtask

  task automatic test_bank_collision();
    logic [TagWidth-1:0]  tag;
    logic [WordWidth-1:0] data;
    tag  = ref_tag[2][5];
    data = {$urandom, $urandom};
    @(negedge clk_i);
    set_read(0, IdxWidth'(5), 1, 1'b0);
    rd_tag_i[0] = tag;
    set_write(2, IdxWidth'(5), 1, data, 8'hff);
    #(ClkPeriod/4);
    check_val("rd_ack_o", 64'(1), 64'(rd_ack_o));
    check_val("wr_ack_o", 64'(0), 64'(wr_ack_o));
    // read moves to bank 3
    @(negedge clk_i);
    rd_off_i[0] = OffWidth'(3 * WordBytes);
    #(ClkPeriod/4);
    check_val("rd_ack_o", 64'(1), 64'(rd_ack_o));
    check_val("wr_ack_o", 64'(1), 64'(wr_ack_o));
    merge_word(2, IdxWidth'(5), 1, data, 8'hff);
    // tag only lookup on the written bank
    @(negedge clk_i);
    data             = {$urandom, $urandom};
    rd_off_i[0]      = OffWidth'(1 * WordBytes);
    rd_tag_only_i[0] = 1'b1;
    set_write(2, IdxWidth'(5), 1, data, 8'hf0);
    #(ClkPeriod/4);
    check_val("rd_ack_o", 64'(1), 64'(rd_ack_o));
    check_val("wr_ack_o", 64'(1), 64'(wr_ack_o));
    merge_word(2, IdxWidth'(5), 1, data, 8'hf0);
    @(negedge clk_i);
    clear_inputs();
    read_check(1, IdxWidth'(5), 1, tag);
  endtask

`endif

//--- testbench/tb_dcache_mem.sv
// data cache memory testbench

module tb_dcache_mem;

  import dcache_geom_pkg::*;
  import dcache_bank_pkg::*;

  localparam int unsigned NumPorts  = 3;
  localparam int unsigned ClkPeriod = 40;
  // the directed tests take well under a hundred cycles
  localparam int unsigned MaxCycles = 2000;

  logic                                 clk_i;
  logic                                 rst_ni;
  logic [NumPorts-1:0]                  rd_req_i;
  logic [NumPorts-1:0][IdxWidth-1:0]    rd_idx_i;
  logic [NumPorts-1:0][OffWidth-1:0]    rd_off_i;
  logic [NumPorts-1:0][TagWidth-1:0]    rd_tag_i;
  logic [NumPorts-1:0]                  rd_tag_only_i;
  logic [NumPorts-1:0]                  rd_prio_i;
  logic [NumPorts-1:0]                  rd_ack_o;
  logic [NumWays-1:0]                   rd_vld_bits_o;
  logic [NumWays-1:0]                   rd_hit_oh_o;
  logic [WordWidth-1:0]                 rd_data_o;
  logic                                 wr_cl_vld_i;
  logic [NumWays-1:0]                   wr_cl_we_i;
  logic [TagWidth-1:0]                  wr_cl_tag_i;
  logic [IdxWidth-1:0]                  wr_cl_idx_i;
  logic [OffWidth-1:0]                  wr_cl_off_i;
  logic [LineWidth-1:0]                 wr_cl_data_i;
  logic [LineWidth/8-1:0]               wr_cl_data_be_i;
  logic [NumWays-1:0]                   wr_vld_bits_i;
  logic [NumWays-1:0]                   wr_req_i;
  logic [IdxWidth-1:0]                  wr_idx_i;
  logic [OffWidth-1:0]                  wr_off_i;
  logic [WordWidth-1:0]                 wr_data_i;
  logic [WordBytes-1:0]                 wr_data_be_i;
  logic                                 wr_ack_o;

  int unsigned errors;
  int unsigned checks;
  int unsigned cycles;

  `include "tb_dcache_tasks.svh"

  dcache_mem #(
    .NumPorts (NumPorts)
  ) u_dcache_mem (.*);

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod/2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // run limit
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    cycles = 0;
    while (cycles < MaxCycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("run stopped after %0d cycles without reaching the end of the tests", cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    errors   = 0;
    checks   = 0;
    void'($urandom(32'he61f_411e));
    clear_inputs();
    rst_ni = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;

    test_reset_state();
    test_refill_read();
    test_refill_bypass();
    test_priority_rr();
    test_word_write();
    test_bank_collision();

    @(negedge clk_i);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+testbench
common/dcache_geom_pkg.sv
common/dcache_bank_pkg.sv
hdl/dcache_rr_arb.sv
hdl/dcache_mem_ctrl.sv
hdl/dcache_tag_array.sv
hdl/dcache_data_banks.sv
hdl/dcache_read_mux.sv
hdl/dcache_mem.sv
testbench/tb_dcache_mem.sv

//--- run.sh
#!/bin/sh
# build and run the data cache memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module tb_dcache_mem -o tb_dcache_mem_sim

./obj_dir/tb_dcache_mem_sim 2>&1 | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "run failed, see sim.log"
  exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
  echo "run ended early, see sim.log"
  exit 1
fi
echo "run passed"
